// ==== files.f ====
hw/nn_pkg.sv
hw/nn_buffer.sv
hw/layer_sequencer.sv
hw/mac_engine.sv
hw/argmax_unit.sv
hw/digit_classifier.sv
sim/tb_digit_classifier.sv

// ==== hw/argmax_unit.sv ====
`timescale 1ns/1ps

module argmax_unit
    import nn_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    clear,
    input  result_t result,
    output class_t  max_class
);

    act_t max_val;
    logic beats_max;

    // Strictly greater, so the lowest index keeps a tie
    assign beats_max = result.valid && (result.value > max_val);

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            max_val   <= ACT_MIN;
            max_class <= '0;
        end else if (clear) begin
            // Index 0 stands in until something beats the floor
            max_val   <= ACT_MIN;
            max_class <= '0;
        end else if (beats_max) begin
            max_val   <= result.value;
            max_class <= class_t'(result.index);
        end
    end

endmodule

// ==== hw/digit_classifier.sv ====
`timescale 1ns/1ps

module digit_classifier
    import nn_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  init,
    input  logic [IMG_PIXELS-1:0] pixel_data,
    input  wt_write_t             wt_load,
    input  logic                  wt_we,
    input  logic                  start,
    output logic                  done,
    output logic                  busy,
    output class_t                class_out
);

    logic [IMG_PIXELS-1:0] image;

    layer_cfg_t cfg;
    logic       layer_start;
    logic       layer_done;

    w_addr_t    w_raddr;
    weight_t    w_rdata;
    a_addr_t    a_raddr;
    a_addr_t    a_waddr;
    act_t       a_rdata0;
    act_t       a_rdata1;
    act_t       a_wdata;
    logic       a_we0;
    logic       a_we1;

    result_t    result;
    result_t    final_result;
    class_t     max_class;
    class_t     class_q;

    // Image and weights only change while idle
    always_ff @(posedge clk) begin
        if (init && !busy) begin
            image <= pixel_data;
        end
    end

    nn_buffer #(
        .elem_t (weight_t),
        .DEPTH  (W_DEPTH)
    ) u_wt_buf (
        .clk   (clk),
        .we    (wt_we && !busy),
        .waddr (wt_load.addr),
        .wdata (wt_load.data),
        .raddr (w_raddr),
        .rdata (w_rdata)
    );

    nn_buffer #(
        .elem_t (act_t),
        .DEPTH  (ACT_DEPTH)
    ) u_act_buf0 (
        .clk   (clk),
        .we    (a_we0),
        .waddr (a_waddr),
        .wdata (a_wdata),
        .raddr (a_raddr),
        .rdata (a_rdata0)
    );

    nn_buffer #(
        .elem_t (act_t),
        .DEPTH  (ACT_DEPTH)
    ) u_act_buf1 (
        .clk   (clk),
        .we    (a_we1),
        .waddr (a_waddr),
        .wdata (a_wdata),
        .raddr (a_raddr),
        .rdata (a_rdata1)
    );

    layer_sequencer u_seq (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .layer_done  (layer_done),
        .cfg         (cfg),
        .layer_start (layer_start),
        .busy        (busy),
        .done        (done)
    );

    mac_engine u_mac (
        .clk         (clk),
        .resetn      (resetn),
        .cfg         (cfg),
        .layer_start (layer_start),
        .image       (image),
        .w_raddr     (w_raddr),
        .w_rdata     (w_rdata),
        .a_raddr     (a_raddr),
        .a_rdata0    (a_rdata0),
        .a_rdata1    (a_rdata1),
        .a_we0       (a_we0),
        .a_we1       (a_we1),
        .a_waddr     (a_waddr),
        .a_wdata     (a_wdata),
        .result      (result),
        .layer_done  (layer_done)
    );

    // Only the last layer's outputs are class scores
    assign final_result = '{valid: result.valid && cfg.last,
                            index: result.index,
                            value: result.value};

    argmax_unit u_argmax (
        .clk       (clk),
        .resetn    (resetn),
        .clear     (layer_start && cfg.src_image),
        .result    (final_result),
        .max_class (max_class)
    );

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            class_q <= '0;
        end else if (done) begin
            class_q <= max_class;
        end
    end

    // Bypass so the new class shows in the done cycle itself
    assign class_out = done ? max_class : class_q;

endmodule

// ==== hw/layer_sequencer.sv ====
`timescale 1ns/1ps

module layer_sequencer
    import nn_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,
    input  logic       layer_done,
    output layer_cfg_t cfg,
    output logic       layer_start,
    output logic       busy,
    output logic       done
);

    seq_state_t state;
    seq_state_t state_next;
    logic       enter_layer;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = LAYER1;
                end
            end
            LAYER1: begin
                if (layer_done) begin
                    state_next = LAYER2;
                end
            end
            LAYER2: begin
                if (layer_done) begin
                    state_next = LAYER3;
                end
            end
            LAYER3: begin
                if (layer_done) begin
                    state_next = FINISH;
                end
            end
            FINISH: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    assign enter_layer = (state_next != state) &&
                         (state_next inside {LAYER1, LAYER2, LAYER3});

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            state       <= IDLE;
            layer_start <= 1'b0;
        end else begin
            state       <= state_next;
            layer_start <= enter_layer;
        end
    end

    // Layer 1 reads the image and writes bank 0, layer 2 goes 0 to 1
    always_comb begin
        cfg = '0;
        case (state)
            LAYER1: begin
                cfg.n_out     = a_addr_t'(L1_OUT);
                cfg.n_in      = in_cnt_t'(IMG_PIXELS);
                cfg.w_base    = w_addr_t'(W1_BASE);
                cfg.src_image = 1'b1;
                cfg.relu      = 1'b1;
            end
            LAYER2: begin
                cfg.n_out    = a_addr_t'(L2_OUT);
                cfg.n_in     = in_cnt_t'(L1_OUT);
                cfg.w_base   = w_addr_t'(W2_BASE);
                cfg.src_bank = 1'b0;
                cfg.relu     = 1'b1;
            end
            LAYER3: begin
                cfg.n_out    = a_addr_t'(L3_OUT);
                cfg.n_in     = in_cnt_t'(L2_OUT);
                cfg.w_base   = w_addr_t'(W3_BASE);
                cfg.src_bank = 1'b1;
                cfg.last     = 1'b1;
            end
            default: begin
                cfg = '0;
            end
        endcase
    end

    assign busy = (state != IDLE);
    // FINISH lets argmax register the tenth result
    assign done = (state == FINISH);

endmodule

// ==== hw/mac_engine.sv ====
`timescale 1ns/1ps

module mac_engine
    import nn_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,
    input  layer_cfg_t            cfg,
    input  logic                  layer_start,
    input  logic [IMG_PIXELS-1:0] image,
    output w_addr_t               w_raddr,
    input  weight_t               w_rdata,
    output a_addr_t               a_raddr,
    input  act_t                  a_rdata0,
    input  act_t                  a_rdata1,
    output logic                  a_we0,
    output logic                  a_we1,
    output a_addr_t               a_waddr,
    output act_t                  a_wdata,
    output result_t               result,
    output logic                  layer_done
);

    // Address stage
    logic    run;
    a_addr_t row;
    in_cnt_t col;
    w_addr_t row_base;
    logic    col_end;
    logic    row_end;

    // Accumulate stage, one cycle behind
    logic    valid_d;
    a_addr_t row_d;
    in_cnt_t col_d;
    logic    col_end_d;
    logic    row_end_d;
    act_t    acc;
    act_t    in_val;
    act_t    wt_ext;
    act_t    prod;
    act_t    sum;
    act_t    sum_act;
    logic    dst_bank;
    logic    row_fin;

    // Output registers
    logic    res_valid;
    a_addr_t res_index;
    act_t    res_value;

    assign col_end = (col == cfg.n_in - in_cnt_t'(1));
    assign row_end = (row == cfg.n_out - a_addr_t'(1));

    assign w_raddr = row_base + w_addr_t'(col);
    assign a_raddr = a_addr_t'(col);

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            run      <= 1'b0;
            row      <= '0;
            col      <= '0;
            row_base <= '0;
        end else if (layer_start) begin
            run      <= 1'b1;
            row      <= '0;
            col      <= '0;
            row_base <= cfg.w_base;
        end else if (run) begin
            if (col_end) begin
                // Next row starts right away, previous sum finishes behind it
                col      <= '0;
                row      <= row + 1'b1;
                row_base <= row_base + w_addr_t'(cfg.n_in);
                if (row_end) begin
                    run <= 1'b0;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            valid_d <= 1'b0;
        end else begin
            valid_d <= run;
        end
    end

    always_ff @(posedge clk) begin
        row_d     <= row;
        col_d     <= col;
        col_end_d <= col_end;
        row_end_d <= row_end;
    end

    always_comb begin
        if (cfg.src_image) begin
            in_val = act_t'(image[col_d[PIX_W-1:0]]);
        end else if (cfg.src_bank) begin
            in_val = a_rdata1;
        end else begin
            in_val = a_rdata0;
        end
    end

    assign wt_ext  = act_t'(w_rdata);
    assign prod    = in_val * wt_ext;
    assign sum     = ((col_d == '0) ? act_t'(0) : acc) + prod;
    assign sum_act = (cfg.relu && sum < 0) ? act_t'(0) : sum;

    // Image layer writes bank 0, others write the bank they do not read
    assign dst_bank = cfg.src_image ? 1'b0 : ~cfg.src_bank;
    assign row_fin  = valid_d && col_end_d;

    always_ff @(posedge clk) begin
        if (valid_d) begin
            acc <= sum;
        end
    end

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            res_valid  <= 1'b0;
            a_we0      <= 1'b0;
            a_we1      <= 1'b0;
            layer_done <= 1'b0;
        end else begin
            res_valid  <= row_fin;
            a_we0      <= row_fin && !cfg.last && !dst_bank;
            a_we1      <= row_fin && !cfg.last && dst_bank;
            layer_done <= row_fin && row_end_d;
        end
    end

    always_ff @(posedge clk) begin
        if (row_fin) begin
            res_index <= row_d;
            res_value <= sum_act;
        end
    end

    assign a_waddr = res_index;
    assign a_wdata = res_value;
    assign result  = '{valid: res_valid, index: res_index, value: res_value};

endmodule

// ==== hw/nn_buffer.sv ====
`timescale 1ns/1ps

module nn_buffer #(
    parameter type elem_t = logic [7:0],
    parameter int  DEPTH  = 16
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  elem_t                    wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output elem_t                    rdata
);

    elem_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, one cycle of latency
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== hw/nn_pkg.sv ====
package nn_pkg;

    // Network shape
    localparam int IMG_PIXELS  = 64;
    localparam int L1_OUT      = 8;
    localparam int L2_OUT      = 8;
    localparam int L3_OUT      = 10;
    localparam int NUM_CLASSES = L3_OUT;

    // Weight rows are stored row-major, one row per output neuron
    localparam int W1_BASE = 0;
    localparam int W2_BASE = W1_BASE + IMG_PIXELS * L1_OUT;
    localparam int W3_BASE = W2_BASE + L1_OUT * L2_OUT;
    localparam int W_DEPTH = W3_BASE + L2_OUT * L3_OUT;

    localparam int ACT_DEPTH = 16;
    localparam int PIX_W     = $clog2(IMG_PIXELS);

    typedef logic signed [7:0]              weight_t;
    typedef logic signed [31:0]             act_t;
    typedef logic [$clog2(W_DEPTH)-1:0]     w_addr_t;
    typedef logic [$clog2(ACT_DEPTH)-1:0]   a_addr_t;
    typedef logic [$clog2(NUM_CLASSES)-1:0] class_t;

    // Input count, wide enough to hold IMG_PIXELS itself
    typedef logic [PIX_W:0] in_cnt_t;

    localparam act_t ACT_MIN = {1'b1, {($bits(act_t) - 1){1'b0}}};

    typedef enum logic [2:0] {
        IDLE,
        LAYER1,
        LAYER2,
        LAYER3,
        FINISH
    } seq_state_t;

    typedef struct packed {
        a_addr_t n_out;
        in_cnt_t n_in;
        w_addr_t w_base;
        logic    src_image;
        logic    src_bank;
        logic    relu;
        logic    last;
    } layer_cfg_t;

    typedef struct packed {
        w_addr_t addr;
        weight_t data;
    } wt_write_t;

    typedef struct packed {
        logic    valid;
        a_addr_t index;
        act_t    value;
    } result_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_digit_classifier -f files.f -o tb_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -q "TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0

// ==== sim/classifier_patterns.hex ====
// Words 0 to 81: weights, 8 bytes per word, lowest weight address in the low byte
// Words 82 to 97: image word (pixel p is bit p) followed by its expected class
// Layer 1, two lines per neuron: +1 on the neuron's own image row, -1 elsewhere
0101010101010101 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF 0101010101010101 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0101010101010101 FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0101010101010101
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF
0101010101010101 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF 0101010101010101 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0101010101010101 FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0101010101010101
// Layer 2: neuron n takes 2 times layer 1 neuron (n+1) mod 8
0000000000000200 0000000000020000 0000000002000000 0000000200000000
0000020000000000 0002000000000000 0200000000000000 0000000000000002
// Layer 3: class c scores 6 times row c, class 8 copies row 4, class 9 is 8 times row 6
0300000000000000 0000000000000003 0000000000000300 0000000000030000
0000000003000000 0000000300000000 0000030000000000 0003000000000000
0000000003000000 0000040000000000
// Images and expected classes
00000000FF000000 0000000000000003 // row 3 full
00000F0000000000 0000000000000005 // half of row 5
030000000000FF00 0000000000000001 // row 1 beats two pixels of row 7
0000003C00000000 0000000000000004 // class 4 ties class 8
00FF000000000000 0000000000000009 // row 6 full, class 9 outscores 6
0101010101010100 0000000000000000 // every layer 1 sum negative
8100000000010000 0000000000000007 // row 7 wins by one
00000000007F0001 0000000000000002 // seven pixels of row 2

// ==== sim/tb_digit_classifier.sv ====
`timescale 1ns/1ps

module tb_digit_classifier
    import nn_pkg::*;
();

    localparam int NUM_IMAGES       = 8;
    localparam int WT_WORDS         = W_DEPTH / 8;
    localparam int PAT_WORDS        = WT_WORDS + 2 * NUM_IMAGES;
    localparam int BUSY_START_DELAY = 20;
    localparam int TIMEOUT_CYCLES   = NUM_IMAGES * IMG_PIXELS * L1_OUT * 2 + 1000;

    logic                  clk;
    logic                  resetn;
    logic                  init;
    logic [IMG_PIXELS-1:0] pixel_data;
    wt_write_t             wt_load;
    logic                  wt_we;
    logic                  start;
    logic                  done;
    logic                  busy;
    class_t                class_out;

    // Weights packed 8 per word, then image and class word pairs
    logic [63:0] patterns [PAT_WORDS];
    int          class_errors;
    int          flag_errors;
    class_t      prev_class;

    digit_classifier dut (
        .clk        (clk),
        .resetn     (resetn),
        .init       (init),
        .pixel_data (pixel_data),
        .wt_load    (wt_load),
        .wt_we      (wt_we),
        .start      (start),
        .done       (done),
        .busy       (busy),
        .class_out  (class_out)
    );

    always #5 clk = ~clk;

    task automatic check_class(input string name, input class_t expected,
                               input class_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %0d actual %0d", name, expected, actual);
            class_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected,
                              input logic actual);
        if (actual !== expected) begin
            $display("Error: %s expected %b actual %b", name, expected, actual);
            flag_errors++;
        end
    endtask

    // Lowest address sits in the low byte of each word
    function automatic weight_t weight_at(input int addr);
        return patterns[addr / 8][8 * (addr % 8) +: 8];
    endfunction

    task automatic load_weights();
        for (int a = 0; a < W_DEPTH; a++) begin
            @(negedge clk);
            wt_load.addr = w_addr_t'(a);
            wt_load.data = weight_at(a);
            wt_we        = 1'b1;
        end
        @(negedge clk);
        wt_we   = 1'b0;
        wt_load = '0;
    endtask

    task automatic classify_image(input int idx, input logic busy_start);
        string                 name;
        logic [IMG_PIXELS-1:0] img;
        class_t                expected;
        int                    cycles;
        name     = $sformatf("image %0d", idx);
        img      = patterns[WT_WORDS + 2 * idx];
        expected = class_t'(patterns[WT_WORDS + 2 * idx + 1]);
        @(negedge clk);
        check_flag({name, " busy while idle"}, 1'b0, busy);
        check_class({name, " class held from last run"}, prev_class, class_out);
        pixel_data = img;
        init       = 1'b1;
        @(negedge clk);
        init  = 1'b0;
        start = 1'b1;
        @(negedge clk);
        start = 0;
        check_flag({name, " busy after start"}, 1'b1, busy);
        cycles = 0;
        while (done !== 1'b1) begin
            check_flag({name, " busy during run"}, 1'b1, busy);
            check_class({name, " class held during run"}, prev_class, class_out);
            cycles++;
            // Second start in the middle of a run must be ignored
            if (busy_start && cycles == BUSY_START_DELAY) begin
                start = 1'b1;
            end else begin
                start = 1'b0;
            end
            @(negedge clk);
        end
        start = 1'b0;
        check_class(name, expected, class_out);
        check_flag({name, " busy with done"}, 1'b1, busy);
        @(negedge clk);
        check_flag({name, " done after one cycle"}, 1'b0, done);
        check_flag({name, " busy after done"}, 1'b0, busy);
        check_class({name, " class after done"}, expected, class_out);
        prev_class = expected;
    endtask

    initial begin
        clk          = 1'b0;
        resetn       = 1'b1;
        init         = 1'b0;
        pixel_data   = '0;
        wt_load      = '0;
        wt_we        = 1'b0;
        start        = 1'b0;
        class_errors = 0;
        flag_errors  = 0;
        prev_class   = '0;
        $readmemh("sim/classifier_patterns.hex", patterns);
        repeat (8) @(negedge clk);
        resetn = 1'b0;
        @(negedge clk);
        check_flag("reset done", 1'b0, done);
        check_flag("reset busy", 1'b0, busy);
        check_class("reset class", class_t'(0), class_out);
        load_weights();
        for (int i = 0; i < NUM_IMAGES; i++) begin
            classify_image(i, (i % 2) == 1);
        end
        repeat (4) @(negedge clk);
        $display("Class errors: %0d, flag errors: %0d", class_errors, flag_errors);
        if (class_errors == 0 && flag_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule
